// ==== project.f ====
+incdir+bench
hdl/rcn_pkg.sv
hdl/rcn_node.sv
hdl/rcn_master.sv
hdl/rcn_timer.sv
hdl/rcn_sram.sv
hdl/rcn_testregs.sv
hdl/rcn_ring_top.sv
bench/rcn_ring_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ring testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module rcn_ring_tb -o rcn_ring_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/rcn_ring_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
  exit 1
fi
exit 0

// ==== bench/rcn_ring_checks.svh ====
/* Ring testbench compare tasks
   One compare per result kind, each stopping the run at the first mismatch */
`ifndef RCN_RING_CHECKS_SVH
`define RCN_RING_CHECKS_SVH

  // Data words from the response port and the test register outputs
  task automatic check_data(input string name, input rcn_data_t got, input rcn_data_t exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  // Error flag that comes back with each response
  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Single-bit levels such as busy, rsp_valid and timer_event
  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

`endif

// ==== bench/rcn_ring_tb.sv ====
/* Ring subsystem testbench
   Seeded random traffic to SRAM, test registers, unmapped addresses and the
   timer, checked against a reference model of the register map */
`default_nettype none
`timescale 1ns/100ps

module rcn_ring_tb;

  import rcn_pkg::*;

  // Round trip in clocks from the command strobe to rsp_valid
  localparam int RSP_LATENCY = 8;
  localparam int PRESCALE    = 4;
  localparam int SRAM_DEPTH  = 256;
  localparam int SRAM_USED   = 64;
  localparam int SRAM_OPS    = 200;
  localparam int TST_OPS     = 30;
  localparam int OOB_CNT     = 4;
  localparam int TMR_CMDS    = 7;
  localparam int NUM_CMDS    = SRAM_USED + SRAM_OPS + 2 * TST_OPS + 3 * OOB_CNT + TMR_CMDS;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * 40 + 2000;
  localparam int EVT_LIMIT   = 20 * PRESCALE + 40;

  localparam rcn_addr_t TMR_BASE = 20'hE0000;
  localparam rcn_addr_t TST_BASE = 20'hFFFF0;

  logic      clk_50;
  logic      rst_n;
  logic      cmd_valid;
  logic      cmd_wr;
  logic [3:0] cmd_mask;
  rcn_addr_t cmd_addr;
  rcn_data_t cmd_wdata;
  logic      busy;
  logic      rsp_valid;
  logic      rsp_err;
  rcn_data_t rsp_rdata;
  rcn_data_t test_progress;
  rcn_data_t test_fail;
  rcn_data_t test_pass;
  logic      timer_event;

  // Reference model state
  rcn_data_t  model_sram [SRAM_DEPTH];
  rcn_data_t  model_tst [3];
  rcn_data_t  model_cmp;
  logic [7:0] sram_idx [SRAM_USED];
  rcn_addr_t  oob_addr [OOB_CNT];
  integer     seed;

  rcn_ring_top #(
    .TMR_ADDR_BASE(TMR_BASE),
    .TST_ADDR_BASE(TST_BASE),
    .SRAM_WORDS   (SRAM_DEPTH),
    .TMR_PRESCALE (PRESCALE)
  ) rcn_ring_top_inst (
    .clk_50       (clk_50),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_wr       (cmd_wr),
    .cmd_mask     (cmd_mask),
    .cmd_addr     (cmd_addr),
    .cmd_wdata    (cmd_wdata),
    .busy         (busy),
    .rsp_valid    (rsp_valid),
    .rsp_err      (rsp_err),
    .rsp_rdata    (rsp_rdata),
    .test_progress(test_progress),
    .test_fail    (test_fail),
    .test_pass    (test_pass),
    .timer_event  (timer_event)
  );

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  `include "rcn_ring_checks.svh"

  initial begin
    clk_50 = 1'b0;
    forever #20 clk_50 = ~clk_50;
  end

  // Expected word after a masked write, built from a per-byte lane mask
  function automatic rcn_data_t apply_mask(input rcn_data_t old_word, input rcn_data_t new_word,
                                           input logic [3:0] mask);
    rcn_data_t lanes;
    lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (old_word & ~lanes) | (new_word & lanes);
  endfunction

  function automatic rcn_addr_t sram_addr(input logic [7:0] idx);
    return {10'd0, idx, 2'b00};
  endfunction

  function automatic rcn_data_t tst_port(input logic [1:0] ofs);
    case (ofs)
      2'd0:    return test_progress;
      2'd1:    return test_fail;
      default: return test_pass;
    endcase
  endfunction

  // One strobe, then busy must hold until rsp_valid shows on the eighth clock
  task automatic issue_cmd(input logic wr, input logic [3:0] mask, input rcn_addr_t addr,
                           input rcn_data_t wdata, output rcn_data_t rdata, output logic err);
    @(posedge clk_50);
    cmd_valid <= 1'b1;
    cmd_wr    <= wr;
    cmd_mask  <= mask;
    cmd_addr  <= addr;
    cmd_wdata <= wdata;
    for (int n = 1; n <= RSP_LATENCY; n++) begin
      @(posedge clk_50);
      if (n == 1) begin
        cmd_valid <= 1'b0;
      end
      #1;
      check_level("rsp_valid", rsp_valid, n == RSP_LATENCY);
      check_level("busy", busy, n != RSP_LATENCY);
    end
    rdata = rsp_rdata;
    err   = rsp_err;
  endtask

  // A write response echoes the write data, not the merged word
  task automatic sram_write(input logic [7:0] idx, input logic [3:0] mask, input rcn_data_t wdata);
    rcn_data_t rdata;
    logic      err;
    issue_cmd(1'b1, mask, sram_addr(idx), wdata, rdata, err);
    check_err("rsp_err", err, 1'b0);
    check_data("rsp_rdata", rdata, wdata);
    model_sram[idx] = apply_mask(model_sram[idx], wdata, mask);
  endtask

  task automatic sram_read(input logic [7:0] idx);
    rcn_data_t rdata;
    logic      err;
    issue_cmd(1'b0, 4'hF, sram_addr(idx), 32'd0, rdata, err);
    check_err("rsp_err", err, 1'b0);
    check_data("rsp_rdata", rdata, model_sram[idx]);
  endtask

  // Write a test register, then compare its output port and its read back
  task automatic tst_update(input logic [1:0] ofs, input logic [3:0] mask, input rcn_data_t wdata);
    rcn_data_t rdata;
    logic      err;
    issue_cmd(1'b1, mask, TST_BASE | {16'd0, ofs, 2'b00}, wdata, rdata, err);
    check_err("rsp_err", err, 1'b0);
    model_tst[ofs] = apply_mask(model_tst[ofs], wdata, mask);
    check_data("test register port", tst_port(ofs), model_tst[ofs]);
    issue_cmd(1'b0, 4'hF, TST_BASE | {16'd0, ofs, 2'b00}, 32'd0, rdata, err);
    check_err("rsp_err", err, 1'b0);
    check_data("rsp_rdata", rdata, model_tst[ofs]);
  endtask

  // Nothing claims the address, so the request comes back as an error
  task automatic unmapped_access(input logic wr, input rcn_addr_t addr, input rcn_data_t wdata);
    rcn_data_t rdata;
    logic      err;
    issue_cmd(wr, 4'hF, addr, wdata, rdata, err);
    check_err("rsp_err", err, 1'b1);
    check_data("rsp_rdata", rdata, 32'd0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_50);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    logic [31:0] r;
    rcn_data_t   rdata;
    rcn_data_t   first_cnt;
    rcn_data_t   second_cnt;
    logic        err;
    logic [1:0]  ofs;
    int          wait_cycles;
    seed      = 32'h57eb;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_wr    = 1'b0;
    cmd_mask  = 4'h0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    model_tst = '{32'd0, 32'd0, 32'd0};
    model_cmp = 32'd0;
    oob_addr  = '{20'h40000, 20'hE0010, 20'h00400, 20'hFFFE0};
    repeat (16) @(posedge clk_50);
    rst_n <= 1'b1;
    #1;
    // Reset state of the host port and the slave outputs
    check_level("busy", busy, 1'b0);
    check_level("rsp_valid", rsp_valid, 1'b0);
    check_level("timer_event", timer_event, 1'b0);
    check_data("test_progress", test_progress, 32'd0);
    check_data("test_fail", test_fail, 32'd0);
    check_data("test_pass", test_pass, 32'd0);

    // SRAM words spread over the whole array, each fully written once first
    for (int i = 0; i < SRAM_USED; i++) begin
      r = $random(seed);
      sram_idx[i] = 8'(i * 4 + int'(r[1:0]));
      sram_write(sram_idx[i], 4'hF, $random(seed));
    end
    for (int i = 0; i < SRAM_OPS; i++) begin
      r = $random(seed);
      if (r[8]) begin
        sram_write(sram_idx[r[5:0]], r[15:12], $random(seed));
      end else begin
        sram_read(sram_idx[r[5:0]]);
      end
    end

    for (int i = 0; i < TST_OPS; i++) begin
      r   = $random(seed);
      ofs = 2'(r % 3);
      tst_update(ofs, r[7:4], $random(seed));
    end

    // Each miss is followed by a normal SRAM read to show the ring recovered
    for (int i = 0; i < OOB_CNT; i++) begin
      unmapped_access(1'b1, oob_addr[i], $random(seed));
      unmapped_access(1'b0, oob_addr[i], 32'd0);
      sram_read(sram_idx[i * 7]);
    end

    issue_cmd(1'b0, 4'hF, TMR_BASE, 32'd0, first_cnt, err);
    check_err("rsp_err", err, 1'b0);
    issue_cmd(1'b0, 4'hF, TMR_BASE, 32'd0, second_cnt, err);
    check_err("rsp_err", err, 1'b0);
    if (!(second_cnt > first_cnt)) begin
      $display("Timer count did not advance between two reads (0x%08h then 0x%08h)",
               first_cnt, second_cnt);
      abort_run();
    end
    // Compare lands 20 ticks past the last count seen
    model_cmp = apply_mask(model_cmp, second_cnt + 32'd20, 4'hF);
    issue_cmd(1'b1, 4'hF, TMR_BASE | 20'h4, second_cnt + 32'd20, rdata, err);
    check_err("rsp_err", err, 1'b0);
    issue_cmd(1'b0, 4'hF, TMR_BASE | 20'h4, 32'd0, rdata, err);
    check_err("rsp_err", err, 1'b0);
    check_data("rsp_rdata", rdata, model_cmp);
    wait_cycles = 0;
    while (!timer_event && wait_cycles < EVT_LIMIT) begin
      @(posedge clk_50);
      #1;
      wait_cycles++;
    end
    check_level("timer_event", timer_event, 1'b1);
    issue_cmd(1'b0, 4'hF, TMR_BASE | 20'h8, 32'd0, rdata, err);
    check_err("rsp_err", err, 1'b0);
    check_data("rsp_rdata", rdata, 32'd1);
    // Writing 1 to status bit 0 clears the event
    issue_cmd(1'b1, 4'h1, TMR_BASE | 20'h8, 32'd1, rdata, err);
    check_err("rsp_err", err, 1'b0);
    check_level("timer_event", timer_event, 1'b0);
    issue_cmd(1'b0, 4'hF, TMR_BASE | 20'h8, 32'd0, rdata, err);
    check_err("rsp_err", err, 1'b0);
    check_data("rsp_rdata", rdata, 32'd0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/rcn_ring_top.sv ====
/* Ring subsystem top level
   Closes the ring from the master through timer, test registers and SRAM
   back to the master, and sets the address window of each slave */
`default_nettype none
`timescale 1ns/100ps

module rcn_ring_top #(
  parameter rcn_pkg::rcn_addr_t TMR_ADDR_MASK  = 20'hFFFF0,
  parameter rcn_pkg::rcn_addr_t TMR_ADDR_BASE  = 20'hE0000,
  parameter rcn_pkg::rcn_addr_t TST_ADDR_MASK  = 20'hFFFF0,
  parameter rcn_pkg::rcn_addr_t TST_ADDR_BASE  = 20'hFFFF0,
  parameter rcn_pkg::rcn_addr_t SRAM_ADDR_MASK = 20'hFFC00,
  parameter rcn_pkg::rcn_addr_t SRAM_ADDR_BASE = 20'h00000,
  parameter int unsigned        SRAM_WORDS     = 256,
  parameter int unsigned        TMR_PRESCALE   = 4
) (
  input  wire                      clk_50,
  input  wire                      rst_n,
  input  wire                      cmd_valid,
  input  wire                      cmd_wr,
  input  wire [3:0]                cmd_mask,
  input  wire rcn_pkg::rcn_addr_t  cmd_addr,
  input  wire rcn_pkg::rcn_data_t  cmd_wdata,
  output wire                      busy,
  output wire                      rsp_valid,
  output wire                      rsp_err,
  output wire rcn_pkg::rcn_data_t  rsp_rdata,
  output wire rcn_pkg::rcn_data_t  test_progress,
  output wire rcn_pkg::rcn_data_t  test_fail,
  output wire rcn_pkg::rcn_data_t  test_pass,
  output wire                      timer_event
);

  import rcn_pkg::*;

  // One link per hop, each driven by the output register of the block before it
  wire rcn_pkt_t ring_mst2tmr;
  wire rcn_pkt_t ring_tmr2tst;
  wire rcn_pkt_t ring_tst2ram;
  wire rcn_pkt_t ring_ram2mst;

  rcn_master rcn_master_inst (
    .clk_50   (clk_50),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd_wr   (cmd_wr),
    .cmd_mask (cmd_mask),
    .cmd_addr (cmd_addr),
    .cmd_wdata(cmd_wdata),
    .busy     (busy),
    .rsp_valid(rsp_valid),
    .rsp_err  (rsp_err),
    .rsp_rdata(rsp_rdata),
    .ring_in  (ring_ram2mst),
    .ring_out (ring_mst2tmr)
  );

  rcn_timer #(
    .ADDR_MASK   (TMR_ADDR_MASK),
    .ADDR_BASE   (TMR_ADDR_BASE),
    .TMR_PRESCALE(TMR_PRESCALE)
  ) rcn_timer_inst (
    .clk_50     (clk_50),
    .rst_n      (rst_n),
    .ring_in    (ring_mst2tmr),
    .ring_out   (ring_tmr2tst),
    .timer_event(timer_event)
  );

  rcn_testregs #(
    .ADDR_MASK(TST_ADDR_MASK),
    .ADDR_BASE(TST_ADDR_BASE)
  ) rcn_testregs_inst (
    .clk_50       (clk_50),
    .rst_n        (rst_n),
    .ring_in      (ring_tmr2tst),
    .ring_out     (ring_tst2ram),
    .test_progress(test_progress),
    .test_fail    (test_fail),
    .test_pass    (test_pass)
  );

  rcn_sram #(
    .ADDR_MASK (SRAM_ADDR_MASK),
    .ADDR_BASE (SRAM_ADDR_BASE),
    .SRAM_WORDS(SRAM_WORDS)
  ) rcn_sram_inst (
    .clk_50  (clk_50),
    .rst_n   (rst_n),
    .ring_in (ring_tst2ram),
    .ring_out(ring_ram2mst)
  );

endmodule

`default_nettype wire

// ==== hdl/rcn_testregs.sv ====
/* Test register slave
   Progress, fail and pass words written over the ring and driven out as
   levels for the testbench to watch */
`default_nettype none
`timescale 1ns/100ps

module rcn_testregs #(
  parameter rcn_pkg::rcn_addr_t ADDR_MASK = 20'hFFFF0,
  parameter rcn_pkg::rcn_addr_t ADDR_BASE = 20'hFFFF0
) (
  input  wire                      clk_50,
  input  wire                      rst_n,
  input  wire rcn_pkg::rcn_pkt_t   ring_in,
  output rcn_pkg::rcn_pkt_t        ring_out,
  output rcn_pkg::rcn_data_t       test_progress,
  output rcn_pkg::rcn_data_t       test_fail,
  output rcn_pkg::rcn_data_t       test_pass
);

  import rcn_pkg::*;

  rcn_slv_req_t slv_req;
  rcn_data_t    slv_rdata;

  rcn_node #(
    .ADDR_MASK(ADDR_MASK),
    .ADDR_BASE(ADDR_BASE)
  ) rcn_node_inst (
    .clk_50   (clk_50),
    .rst_n    (rst_n),
    .ring_in  (ring_in),
    .ring_out (ring_out),
    .slv_req  (slv_req),
    .slv_rdata(slv_rdata)
  );

  // The registers are the output ports, so a write shows up on the next clock
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      test_progress <= '0;
      test_fail     <= '0;
      test_pass     <= '0;
    end else if (slv_req.strobe && slv_req.wr) begin
      case (slv_req.ofs)
        TST_PROGRESS_OFS: test_progress <= rcn_byte_merge(test_progress, slv_req.wdata,
                                                          slv_req.mask);
        TST_FAIL_OFS:     test_fail <= rcn_byte_merge(test_fail, slv_req.wdata, slv_req.mask);
        TST_PASS_OFS:     test_pass <= rcn_byte_merge(test_pass, slv_req.wdata, slv_req.mask);
        default:          ;
      endcase
    end
  end

  // Registered read back, unused offsets read as zero
  always_ff @(posedge clk_50) begin
    if (slv_req.strobe && !slv_req.wr) begin
      case (slv_req.ofs)
        TST_PROGRESS_OFS: slv_rdata <= test_progress;
        TST_FAIL_OFS:     slv_rdata <= test_fail;
        TST_PASS_OFS:     slv_rdata <= test_pass;
        default:          slv_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rcn_sram.sv ====
/* SRAM slave
   Word-addressed synchronous memory behind a ring stop, with a write enable
   per byte lane and a registered read port */
`default_nettype none
`timescale 1ns/100ps

module rcn_sram #(
  parameter rcn_pkg::rcn_addr_t ADDR_MASK  = 20'hFFC00,
  parameter rcn_pkg::rcn_addr_t ADDR_BASE  = 20'h00000,
  parameter int unsigned        SRAM_WORDS = 256
) (
  input  wire                      clk_50,
  input  wire                      rst_n,
  input  wire rcn_pkg::rcn_pkt_t   ring_in,
  output rcn_pkg::rcn_pkt_t        ring_out
);

  import rcn_pkg::*;

  localparam int AW = $clog2(SRAM_WORDS);

  rcn_slv_req_t  slv_req;
  rcn_data_t     slv_rdata;
  rcn_data_t     mem [SRAM_WORDS];
  logic [AW-1:0] idx;

  rcn_node #(
    .ADDR_MASK(ADDR_MASK),
    .ADDR_BASE(ADDR_BASE)
  ) rcn_node_inst (
    .clk_50   (clk_50),
    .rst_n    (rst_n),
    .ring_in  (ring_in),
    .ring_out (ring_out),
    .slv_req  (slv_req),
    .slv_rdata(slv_rdata)
  );

  // Word index inside the array, upper offset bits fold onto it
  assign idx = slv_req.ofs[AW-1:0];

  // Each mask bit enables one byte lane, the contents are not initialized
  always_ff @(posedge clk_50) begin
    if (slv_req.strobe && slv_req.wr) begin
      for (int b = 0; b < 4; b++) begin
        if (slv_req.mask[b]) begin
          mem[idx][8*b +: 8] <= slv_req.wdata[8*b +: 8];
        end
      end
    end
    if (slv_req.strobe && !slv_req.wr) begin
      slv_rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rcn_timer.sv ====
/* Timer slave
   Prescaled 32-bit up counter with a compare register, raising an event level
   that holds until software clears it through the status register */
`default_nettype none
`timescale 1ns/100ps

module rcn_timer #(
  parameter rcn_pkg::rcn_addr_t ADDR_MASK    = 20'hFFFF0,
  parameter rcn_pkg::rcn_addr_t ADDR_BASE    = 20'hE0000,
  parameter int unsigned        TMR_PRESCALE = 4
) (
  input  wire                      clk_50,
  input  wire                      rst_n,
  input  wire rcn_pkg::rcn_pkt_t   ring_in,
  output rcn_pkg::rcn_pkt_t        ring_out,
  output logic                     timer_event
);

  import rcn_pkg::*;

  localparam int PW = (TMR_PRESCALE > 1) ? $clog2(TMR_PRESCALE) : 1;

  rcn_slv_req_t  slv_req;
  rcn_data_t     slv_rdata;
  logic [PW-1:0] pre_cnt;
  logic          tick;
  rcn_data_t     count;
  rcn_data_t     cmp;
  logic          wr_cmp;
  logic          clr_evt;

  rcn_node #(
    .ADDR_MASK(ADDR_MASK),
    .ADDR_BASE(ADDR_BASE)
  ) rcn_node_inst (
    .clk_50   (clk_50),
    .rst_n    (rst_n),
    .ring_in  (ring_in),
    .ring_out (ring_out),
    .slv_req  (slv_req),
    .slv_rdata(slv_rdata)
  );

  assign tick    = (pre_cnt == PW'(TMR_PRESCALE - 1));
  assign wr_cmp  = slv_req.strobe && slv_req.wr && (slv_req.ofs == TMR_CMP_OFS);
  // Status clears only on a written 1 in bit 0 with its byte lane enabled
  assign clr_evt = slv_req.strobe && slv_req.wr && (slv_req.ofs == TMR_STATUS_OFS) &&
                   slv_req.mask[0] && slv_req.wdata[0];

  // Count advances once every TMR_PRESCALE clocks
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      pre_cnt <= '0;
      count   <= '0;
    end else if (tick) begin
      pre_cnt <= '0;
      count   <= count + 32'd1;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  // Compare starts at all ones so no event fires soon after reset
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      cmp <= '1;
    end else if (wr_cmp) begin
      cmp <= rcn_byte_merge(cmp, slv_req.wdata, slv_req.mask);
    end
  end

  // The flag sets on the tick that brings count onto compare
  // A clear in the same cycle loses against a new match
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      timer_event <= 1'b0;
    end else if (tick && ((count + 32'd1) == cmp)) begin
      timer_event <= 1'b1;
    end else if (clr_evt) begin
      timer_event <= 1'b0;
    end
  end

  // Read word is registered and ready one cycle after the strobe
  always_ff @(posedge clk_50) begin
    if (slv_req.strobe && !slv_req.wr) begin
      case (slv_req.ofs)
        TMR_COUNT_OFS:  slv_rdata <= count;
        TMR_CMP_OFS:    slv_rdata <= cmp;
        TMR_STATUS_OFS: slv_rdata <= {31'd0, timer_event};
        default:        slv_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rcn_master.sv ====
/* Ring master
   Turns a host command into a request packet, puts it on the ring and waits
   for the same slot to come back as a response or as an unclaimed request */
`default_nettype none
`timescale 1ns/100ps

module rcn_master (
  input  wire                      clk_50,
  input  wire                      rst_n,
  input  wire                      cmd_valid,
  input  wire                      cmd_wr,
  input  wire [3:0]                cmd_mask,
  input  wire rcn_pkg::rcn_addr_t  cmd_addr,
  input  wire rcn_pkg::rcn_data_t  cmd_wdata,
  output logic                     busy,
  output logic                     rsp_valid,
  output logic                     rsp_err,
  output rcn_pkg::rcn_data_t       rsp_rdata,
  input  wire rcn_pkg::rcn_pkt_t   ring_in,
  output rcn_pkg::rcn_pkt_t        ring_out
);

  import rcn_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT
  } state_t;

  state_t   state;
  rcn_pkt_t req_pkt;

  // Request packet built straight from the host command
  always_comb begin
    req_pkt.valid = 1'b1;
    req_pkt.req   = 1'b1;
    req_pkt.wr    = cmd_wr;
    req_pkt.mask  = cmd_mask;
    req_pkt.addr  = cmd_addr;
    req_pkt.data  = cmd_wdata;
  end

  // Busy covers the whole round trip and drops together with rsp_valid
  assign busy = (state != IDLE);

  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      ring_out  <= '0;
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
      rsp_rdata <= '0;
    end else begin
      // The master owns its slot for one cycle, after that it sends empty slots
      ring_out  <= '0;
      rsp_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_valid) begin
            ring_out <= req_pkt;
            state    <= SEND;
          end
        end
        SEND: begin
          // Packet is on the ring now
          state <= WAIT;
        end
        WAIT: begin
          // With one request outstanding the first valid slot back is ours
          // A packet still marked as a request was claimed by no slave
          if (ring_in.valid) begin
            rsp_valid <= 1'b1;
            rsp_err   <= ring_in.req;
            rsp_rdata <= ring_in.req ? '0 : ring_in.data;
            state     <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // The host has no back-pressure and must wait for busy to drop
  a_no_cmd_when_busy: assert property (@(posedge clk_50) disable iff (!rst_n)
    cmd_valid |-> !busy);

  // Nothing may come back around the ring unless a request is in flight
  a_no_stray_return: assert property (@(posedge clk_50) disable iff (!rst_n)
    ring_in.valid |-> (state != IDLE));

endmodule

`default_nettype wire

// ==== hdl/rcn_node.sv ====
/* Ring stop
   Two-stage pipeline on the ring that claims requests inside its address window,
   offers them to the attached slave and turns them into responses */
`default_nettype none
`timescale 1ns/100ps

module rcn_node #(
  parameter rcn_pkg::rcn_addr_t ADDR_MASK = 20'hFFFF0,
  parameter rcn_pkg::rcn_addr_t ADDR_BASE = 20'hFFFF0
) (
  input  wire                        clk_50,
  input  wire                        rst_n,
  input  wire rcn_pkg::rcn_pkt_t     ring_in,
  output rcn_pkg::rcn_pkt_t          ring_out,
  output rcn_pkg::rcn_slv_req_t      slv_req,
  input  wire rcn_pkg::rcn_data_t    slv_rdata
);

  import rcn_pkg::*;

  // Address bits below the window size select the word inside the slave
  localparam rcn_addr_t OFS_MASK = ~ADDR_MASK;

  logic     hit;
  rcn_pkt_t pkt_q;
  logic     hit_q;

  // Only live requests inside the window are claimed, responses always pass
  assign hit = ring_in.valid && ring_in.req && ((ring_in.addr & ADDR_MASK) == ADDR_BASE);

  // The slave sees the request in the same cycle the packet enters stage 1,
  // so its registered read word is ready when stage 2 loads
  always_comb begin
    slv_req.strobe = hit;
    slv_req.wr     = ring_in.wr;
    slv_req.mask   = ring_in.mask;
    slv_req.ofs    = ring_in.addr[9:2] & OFS_MASK[9:2];
    slv_req.wdata  = ring_in.data;
  end

  // Stage 1 holds the packet and remembers whether it was claimed
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      pkt_q <= '0;
      hit_q <= 1'b0;
    end else begin
      pkt_q <= ring_in;
      hit_q <= hit;
    end
  end

  // Stage 2 turns a claimed request into a response in the same slot
  // Address and mask stay, a write echoes its data and a read takes the slave word
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      ring_out <= '0;
    end else if (hit_q) begin
      ring_out      <= pkt_q;
      ring_out.req  <= 1'b0;
      ring_out.data <= pkt_q.wr ? pkt_q.data : slv_rdata;
    end else begin
      ring_out <= pkt_q;
    end
  end

  // An empty slot coming from upstream must never carry the request flag
  a_idle_slot_clean: assert property (@(posedge clk_50) disable iff (!rst_n)
    !(ring_in.req && !ring_in.valid));

endmodule

`default_nettype wire

// ==== hdl/rcn_pkg.sv ====
/* Ring bus package
   Packet layout, the request a ring stop hands to its slave, slave register
   offsets and the byte-lane merge shared by the register slaves */
`default_nettype none

package rcn_pkg;

  // Byte address and data word carried on the ring
  typedef logic [19:0] rcn_addr_t;
  typedef logic [31:0] rcn_data_t;

  // Word offset seen by a slave inside its own window
  typedef logic [7:0] rcn_ofs_t;

  // One ring slot, with valid and req in the top bits
  typedef struct packed {
    logic      valid;
    logic      req;
    logic      wr;
    logic [3:0] mask;
    rcn_addr_t addr;
    rcn_data_t data;
  } rcn_pkt_t;

  // Request offered by a ring stop to the slave behind it
  typedef struct packed {
    logic      strobe;
    logic      wr;
    logic [3:0] mask;
    rcn_ofs_t  ofs;
    rcn_data_t wdata;
  } rcn_slv_req_t;

  // Timer register map in words
  localparam rcn_ofs_t TMR_COUNT_OFS  = 8'd0;
  localparam rcn_ofs_t TMR_CMP_OFS    = 8'd1;
  localparam rcn_ofs_t TMR_STATUS_OFS = 8'd2;

  // Test register map in words
  localparam rcn_ofs_t TST_PROGRESS_OFS = 8'd0;
  localparam rcn_ofs_t TST_FAIL_OFS     = 8'd1;
  localparam rcn_ofs_t TST_PASS_OFS     = 8'd2;

  // Replaces the bytes of old_word selected by mask, bit i covering byte i
  function automatic rcn_data_t rcn_byte_merge(rcn_data_t old_word, rcn_data_t new_word,
                                               logic [3:0] mask);
    rcn_data_t merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire
